//--- rtl/adc_pkg.sv
package adc_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADC_LANES = 7;              // data lanes per channel
  localparam int ADC_RAW_W = 2 * ADC_LANES;  // two beats per code
  localparam int ADC_OUT_W = 16;             // left aligned sample
  localparam int ADC_CH_N  = 2;

  //////////////////////////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////////////////////////

  // one beat on the lanes of both channels
  typedef struct packed {
    logic [ADC_LANES-1:0] ch1;
    logic [ADC_LANES-1:0] ch0;
  } adc_lanes_t;

  // aligned output pair, channels already crossed
  typedef struct packed {
    logic [ADC_OUT_W-1:0] ch_a;  // from channel 1
    logic [ADC_OUT_W-1:0] ch_b;  // from channel 0
  } adc_sample_t;

endpackage

//--- rtl/sys_bus_pkg.sv
package sys_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////////////////////////

  localparam int SYS_ADDR_W = 23;
  localparam int SYS_SLOT_W = 3;   // top address bits
  localparam int SYS_OFFS_W = 20;  // low address bits
  localparam int SYS_DATA_W = 32;
  localparam int SYS_SLOT_N = 8;

  localparam logic [SYS_SLOT_W-1:0] SLOT_HK = 3'd3;  // housekeeping

  //////////////////////////////////////////////////////////////////////
  // housekeeping map
  //////////////////////////////////////////////////////////////////////

  localparam logic [SYS_OFFS_W-1:0] REG_ID        = 20'h00000;
  localparam logic [SYS_OFFS_W-1:0] REG_EXP_P_DIR = 20'h00010;
  localparam logic [SYS_OFFS_W-1:0] REG_EXP_N_DIR = 20'h00014;
  localparam logic [SYS_OFFS_W-1:0] REG_EXP_P_OUT = 20'h00018;
  localparam logic [SYS_OFFS_W-1:0] REG_EXP_N_OUT = 20'h0001C;
  localparam logic [SYS_OFFS_W-1:0] REG_EXP_P_IN  = 20'h00020;  // read only
  localparam logic [SYS_OFFS_W-1:0] REG_EXP_N_IN  = 20'h00024;  // read only
  localparam logic [SYS_OFFS_W-1:0] REG_LED       = 20'h00030;

  localparam logic [SYS_DATA_W-1:0] HK_ID_VALUE = 32'h0000_0001;

  localparam int EXP_W = 9;  // pins per connector row
  localparam int LED_W = 8;

  //////////////////////////////////////////////////////////////////////
  // bus and pin types
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [SYS_ADDR_W-1:0] addr;
    logic [SYS_DATA_W-1:0] wdata;
    logic                  wen;   // one cycle strobe
    logic                  ren;   // one cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [SYS_DATA_W-1:0] rdata;  // valid with read ack
    logic                  err;    // valid with ack
    logic                  ack;
  } sys_rsp_t;

  typedef struct packed {
    logic [EXP_W-1:0] p;
    logic [EXP_W-1:0] n;
  } exp_pins_t;

endpackage

//--- rtl/adc_frontend.sv
module adc_frontend
  import adc_pkg::*;
(
  input  logic        clk_250,
  input  logic        rst_n_i,
  input  adc_lanes_t  adc_lanes_i,
  input  logic        adc_frame_i,   // high on even bit beat
  output adc_sample_t adc_dat_o,
  output logic        adc_vld_o
);

  logic [ADC_CH_N-1:0][ADC_LANES-1:0] lanes;
  logic [ADC_CH_N-1:0][ADC_LANES-1:0] even_q;  // first beat, held
  logic                               pend_q;  // first beat waiting
  logic [ADC_CH_N-1:0][ADC_RAW_W-1:0] code;
  logic [ADC_CH_N-1:0][ADC_RAW_W-1:0] cap_q;
  logic                               cap_vld_q;
  adc_sample_t                        sw_q;
  logic                               sw_vld_q;

  assign lanes[0] = adc_lanes_i.ch0;
  assign lanes[1] = adc_lanes_i.ch1;

  //////////////////////////////////////////////////////////////////////
  // two beat capture
  //////////////////////////////////////////////////////////////////////

  // interleave held even bits with odd bits of current beat
  always_comb
  begin
    for (int c = 0; c < ADC_CH_N; c++)
    begin
      for (int k = 0; k < ADC_LANES; k++)
      begin
        code[c][2*k]   = even_q[c][k];
        code[c][2*k+1] = lanes[c][k];
      end
    end
  end

  always_ff @(posedge clk_250 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pend_q    <= 1'b0;
      cap_vld_q <= 1'b0;
    end
    else
    begin
      cap_vld_q <= !adc_frame_i && pend_q;  // second beat completes code
      if (adc_frame_i)
        pend_q <= 1'b1;  // later first beat overrides
      else
        pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_250)
  begin
    if (adc_frame_i)
      even_q <= lanes;
    if (!adc_frame_i && pend_q)
      cap_q <= code;
  end

  //////////////////////////////////////////////////////////////////////
  // swap and align
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_250 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sw_vld_q  <= 1'b0;
      adc_vld_o <= 1'b0;
    end
    else
    begin
      sw_vld_q  <= cap_vld_q;
      adc_vld_o <= sw_vld_q;
    end
  end

  always_ff @(posedge clk_250)
  begin
    sw_q.ch_a <= {cap_q[1], {(ADC_OUT_W-ADC_RAW_W){1'b0}}};  // adc b -> ch a
    sw_q.ch_b <= {cap_q[0], {(ADC_OUT_W-ADC_RAW_W){1'b0}}};  // adc a -> ch b
    adc_dat_o <= sw_q;
  end

endmodule

//--- rtl/sys_bus_decode.sv
module sys_bus_decode
  import sys_bus_pkg::*;
(
  input  logic     clk_250,
  input  logic     rst_n_i,
  input  sys_req_t sys_req_i,
  output sys_rsp_t sys_rsp_o,
  output sys_req_t hk_req_o,
  input  sys_rsp_t hk_rsp_i
);

  logic [SYS_SLOT_W-1:0] slot;
  logic [SYS_SLOT_N-1:0] slot_sel;     // one hot
  logic                  hk_sel;
  logic                  stub_ack_q;   // unmapped slot answer
  logic                  ack_q;
  logic                  err_q;
  logic [SYS_DATA_W-1:0] rdata_q;

  //////////////////////////////////////////////////////////////////////
  // slot decode
  //////////////////////////////////////////////////////////////////////

  assign slot     = sys_req_i.addr[SYS_ADDR_W-1 -: SYS_SLOT_W];
  assign slot_sel = SYS_SLOT_N'(1) << slot;
  assign hk_sel   = slot_sel[SLOT_HK];

  // request passes through, strobes only toward the selected slot
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen && hk_sel;
    hk_req_o.ren = sys_req_i.ren && hk_sel;
  end

  //////////////////////////////////////////////////////////////////////
  // stub and response register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_250 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      stub_ack_q <= 1'b0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end
    else
    begin
      stub_ack_q <= (sys_req_i.wen || sys_req_i.ren) && !hk_sel;  // same delay as hk
      ack_q      <= hk_rsp_i.ack || stub_ack_q;
      err_q      <= stub_ack_q || (hk_rsp_i.ack && hk_rsp_i.err);
    end
  end

  always_ff @(posedge clk_250)
  begin
    if (hk_rsp_i.ack)
      rdata_q <= hk_rsp_i.rdata;
    else
      rdata_q <= '0;  // stub reads as zero
  end

  assign sys_rsp_o.rdata = rdata_q;
  assign sys_rsp_o.err   = err_q;
  assign sys_rsp_o.ack   = ack_q;

endmodule

//--- rtl/hk_regs.sv
module hk_regs
  import sys_bus_pkg::*;
(
  input  logic             clk_250,
  input  logic             rst_n_i,
  input  sys_req_t         req_i,
  output sys_rsp_t         rsp_o,
  input  exp_pins_t        exp_in_i,   // async pins
  output exp_pins_t        exp_out_o,
  output exp_pins_t        exp_oe_o,   // 1 drives the pin
  output logic [LED_W-1:0] led_o
);

  logic [SYS_OFFS_W-1:0] offs;
  exp_pins_t             exp_dir_q;
  exp_pins_t             exp_out_q;
  logic [LED_W-1:0]      led_q;
  exp_pins_t             exp_meta_q;   // first sync flop
  exp_pins_t             exp_sync_q;
  logic [SYS_DATA_W-1:0] rd_mux;
  logic [SYS_DATA_W-1:0] rdata_q;
  logic                  ack_q;

  assign offs = req_i.addr[SYS_OFFS_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // input synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_250 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      exp_meta_q <= '0;
      exp_sync_q <= '0;
    end
    else
    begin
      exp_meta_q <= exp_in_i;
      exp_sync_q <= exp_meta_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_250 or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      exp_dir_q <= '0;  // all pins input
      exp_out_q <= '0;
      led_q     <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen || req_i.ren;  // every strobe acked next cycle
      if (req_i.wen)
      begin
        case (offs)
          REG_EXP_P_DIR: exp_dir_q.p <= req_i.wdata[EXP_W-1:0];
          REG_EXP_N_DIR: exp_dir_q.n <= req_i.wdata[EXP_W-1:0];
          REG_EXP_P_OUT: exp_out_q.p <= req_i.wdata[EXP_W-1:0];
          REG_EXP_N_OUT: exp_out_q.n <= req_i.wdata[EXP_W-1:0];
          REG_LED:       led_q       <= req_i.wdata[LED_W-1:0];
          default:       ;  // id, inputs and holes
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (offs)
      REG_ID:        rd_mux = HK_ID_VALUE;
      REG_EXP_P_DIR: rd_mux = SYS_DATA_W'(exp_dir_q.p);
      REG_EXP_N_DIR: rd_mux = SYS_DATA_W'(exp_dir_q.n);
      REG_EXP_P_OUT: rd_mux = SYS_DATA_W'(exp_out_q.p);
      REG_EXP_N_OUT: rd_mux = SYS_DATA_W'(exp_out_q.n);
      REG_EXP_P_IN:  rd_mux = SYS_DATA_W'(exp_sync_q.p);
      REG_EXP_N_IN:  rd_mux = SYS_DATA_W'(exp_sync_q.n);
      REG_LED:       rd_mux = SYS_DATA_W'(led_q);
      default:       rd_mux = '0;  // unknown offset, no error
    endcase
  end

  always_ff @(posedge clk_250)
  begin
    if (req_i.ren)
      rdata_q <= rd_mux;
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;  // slot never errors
  assign rsp_o.ack   = ack_q;

  assign exp_oe_o  = exp_dir_q;
  assign exp_out_o = exp_out_q;
  assign led_o     = led_q;

endmodule

//--- rtl/rp_core_top.sv
module rp_core_top
  import adc_pkg::*;
  import sys_bus_pkg::*;
(
  input  logic             clk_250,
  input  logic             rst_n_i,
  // adc
  input  adc_lanes_t       adc_lanes_i,
  input  logic             adc_frame_i,
  output adc_sample_t      adc_dat_o,
  output logic             adc_vld_o,
  // system bus
  input  sys_req_t         sys_req_i,
  output sys_rsp_t         sys_rsp_o,
  // expansion connector and leds
  input  exp_pins_t        exp_in_i,
  output exp_pins_t        exp_out_o,
  output exp_pins_t        exp_oe_o,
  output logic [LED_W-1:0] led_o
);

  sys_req_t hk_req;  // slot 3 request
  sys_rsp_t hk_rsp;

  //////////////////////////////////////////////////////////////////////
  // adc path
  //////////////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_inst (
    .clk_250     (clk_250),
    .rst_n_i     (rst_n_i),
    .adc_lanes_i (adc_lanes_i),
    .adc_frame_i (adc_frame_i),
    .adc_dat_o   (adc_dat_o),
    .adc_vld_o   (adc_vld_o)
  );

  //////////////////////////////////////////////////////////////////////
  // bus and housekeeping
  //////////////////////////////////////////////////////////////////////

  sys_bus_decode sys_bus_decode_inst (
    .clk_250   (clk_250),
    .rst_n_i   (rst_n_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp)
  );

  hk_regs hk_regs_inst (
    .clk_250   (clk_250),
    .rst_n_i   (rst_n_i),
    .req_i     (hk_req),
    .rsp_o     (hk_rsp),
    .exp_in_i  (exp_in_i),
    .exp_out_o (exp_out_o),
    .exp_oe_o  (exp_oe_o),   // direction regs
    .led_o     (led_o)
  );

endmodule

//--- testbench/rp_core_chk.sv
module rp_core_chk
  import sys_bus_pkg::*;
(
  input logic             clk_250,
  input logic             rst_n_i,
  input sys_req_t         sys_req_i,
  input sys_rsp_t         sys_rsp_o,
  input logic             adc_vld_o,
  input exp_pins_t        exp_out_o,
  input exp_pins_t        exp_oe_o,
  input logic [LED_W-1:0] led_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int   fail_cnt = 0;  // assertion failures so far
  logic strobe;

  assign strobe = sys_req_i.wen || sys_req_i.ren;

  //////////////////////////////////////////////////////////////////////
  // bus timing
  //////////////////////////////////////////////////////////////////////

  a_ack_lat: assert property (@(posedge clk_250) disable iff (!rst_n_i)
    strobe |-> ##2 sys_rsp_o.ack)
    else
    begin
      $error("ack missing two cycles after strobe");
      fail_cnt++;
    end

  a_ack_src: assert property (@(posedge clk_250) disable iff (!rst_n_i)
    sys_rsp_o.ack |-> $past(strobe, 2))  // no ack without a strobe
    else
    begin
      $error("ack without a strobe two cycles before");
      fail_cnt++;
    end

  a_one_strobe: assert property (@(posedge clk_250) disable iff (!rst_n_i)
    !(sys_req_i.wen && sys_req_i.ren))
    else
    begin
      $error("wen and ren high together");
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // samples and reset
  //////////////////////////////////////////////////////////////////////

  a_vld_gap: assert property (@(posedge clk_250) disable iff (!rst_n_i)
    adc_vld_o |=> !adc_vld_o)  // two beats per sample
    else
    begin
      $error("adc_vld_o high in consecutive cycles");
      fail_cnt++;
    end

  a_rst_quiet: assert property (@(posedge clk_250)
    !rst_n_i |-> (!adc_vld_o && !sys_rsp_o.ack && !sys_rsp_o.err
                  && exp_oe_o == '0 && exp_out_o == '0 && led_o == '0))
    else
    begin
      $error("outputs not low during reset");
      fail_cnt++;
    end

endmodule

bind rp_core_top rp_core_chk rp_core_chk_inst (.*);

//--- testbench/tb_top.sv
module tb_top
  import adc_pkg::*;
  import sys_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYC  = 4;
  localparam int N_SAMPLES  = 40;  // back to back random samples
  localparam int N_TXN      = 32;  // upper bound on bus accesses
  localparam int TXN_CYC    = 6;   // strobe, two cycle ack, slack
  localparam int WDOG_CYC   = RESET_CYC + 2 * N_SAMPLES + N_TXN * TXN_CYC + 100;

  logic             clk_250 = 1'b0;
  logic             rst_n_i;
  adc_lanes_t       adc_lanes_i;
  logic             adc_frame_i;
  adc_sample_t      adc_dat_o;
  logic             adc_vld_o;
  sys_req_t         sys_req_i;
  sys_rsp_t         sys_rsp_o;
  exp_pins_t        exp_in_i;
  exp_pins_t        exp_out_o;
  exp_pins_t        exp_oe_o;
  logic [LED_W-1:0] led_o;

  adc_sample_t           exp_q[$];  // expected samples, oldest first
  int                    due_q[$];  // negedge count where each must show
  int                    cyc = 0;
  exp_pins_t             mdl_dir;   // register model
  exp_pins_t             mdl_out;
  exp_pins_t             mdl_in;    // pins as driven
  logic [LED_W-1:0]      mdl_led;
  logic [SYS_OFFS_W-1:0] rw_regs [5] = '{REG_LED, REG_EXP_P_DIR, REG_EXP_N_DIR,
                                         REG_EXP_P_OUT, REG_EXP_N_OUT};

  rp_core_top rp_core_top_inst (.*);

  always #(CLK_PERIOD / 2) clk_250 = ~clk_250;

  always @(posedge clk_250)
    cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // reference models
  //////////////////////////////////////////////////////////////////////

  // even beat gives bit 2k, odd beat bit 2k+1, channels crossed
  function automatic adc_sample_t ref_sample(adc_lanes_t even, adc_lanes_t odd);
    adc_sample_t          s;
    logic [ADC_RAW_W-1:0] c0;
    logic [ADC_RAW_W-1:0] c1;
    for (int k = 0; k < ADC_LANES; k++)
    begin
      c0[2*k]   = even.ch0[k];
      c0[2*k+1] = odd.ch0[k];
      c1[2*k]   = even.ch1[k];
      c1[2*k+1] = odd.ch1[k];
    end
    s.ch_a = {c1, 2'b00};  // channel 1 left aligned
    s.ch_b = {c0, 2'b00};
    return s;
  endfunction

  function automatic logic [SYS_DATA_W-1:0] ref_read(logic [SYS_OFFS_W-1:0] offs);
    case (offs)
      REG_ID:        return HK_ID_VALUE;
      REG_EXP_P_DIR: return SYS_DATA_W'(mdl_dir.p);
      REG_EXP_N_DIR: return SYS_DATA_W'(mdl_dir.n);
      REG_EXP_P_OUT: return SYS_DATA_W'(mdl_out.p);
      REG_EXP_N_OUT: return SYS_DATA_W'(mdl_out.n);
      REG_EXP_P_IN:  return SYS_DATA_W'(mdl_in.p);
      REG_EXP_N_IN:  return SYS_DATA_W'(mdl_in.n);
      REG_LED:       return SYS_DATA_W'(mdl_led);
      default:       return '0;  // holes read zero
    endcase
  endfunction

  function automatic void model_write(logic [SYS_OFFS_W-1:0] offs,
                                      logic [SYS_DATA_W-1:0] data);
    case (offs)
      REG_EXP_P_DIR: mdl_dir.p = data[EXP_W-1:0];
      REG_EXP_N_DIR: mdl_dir.n = data[EXP_W-1:0];
      REG_EXP_P_OUT: mdl_out.p = data[EXP_W-1:0];
      REG_EXP_N_OUT: mdl_out.n = data[EXP_W-1:0];
      REG_LED:       mdl_led   = data[LED_W-1:0];
      default:       ;  // id and inputs are read only
    endcase
  endfunction

  function automatic adc_lanes_t rnd_lanes();
    logic [31:0] r;
    r = $urandom;
    return r[$bits(adc_lanes_t)-1:0];
  endfunction

  function automatic exp_pins_t rnd_pins();
    logic [31:0] r;
    r = $urandom;
    return r[$bits(exp_pins_t)-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(string name, adc_sample_t got, adc_sample_t exp);
    if (got !== exp)
      abort_run($sformatf("Error: time %0t, %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_rsp(string name, sys_rsp_t got, sys_rsp_t exp, bit with_rdata);
    logic bad;
    bad = (got.err !== exp.err) || (got.ack !== exp.ack);
    if (with_rdata && (got.rdata !== exp.rdata))  // rdata defined on reads only
      bad = 1'b1;
    if (bad)
      abort_run($sformatf("Error: time %0t, %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_pins(string name, exp_pins_t got, exp_pins_t exp);
    if (got !== exp)
      abort_run($sformatf("Error: time %0t, %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_led(string name, logic [LED_W-1:0] got, logic [LED_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Error: time %0t, %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
      abort_run($sformatf("Error: time %0t, %s got %b expected %b", $time, name, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic send_sample(adc_lanes_t even, adc_lanes_t odd);
    @(posedge clk_250);
    adc_lanes_i <= even;
    adc_frame_i <= 1'b1;  // first beat
    @(posedge clk_250);
    adc_lanes_i <= odd;
    adc_frame_i <= 1'b0;
    exp_q.push_back(ref_sample(even, odd));
    due_q.push_back(cyc + 4);  // vld 3 edges on, seen at next negedge
  endtask

  task automatic bus_access(bit write, logic [SYS_ADDR_W-1:0] addr,
                            logic [SYS_DATA_W-1:0] wdata, output sys_rsp_t rsp);
    int waited;
    @(posedge clk_250);
    sys_req_i.addr  <= addr;
    sys_req_i.wdata <= wdata;
    sys_req_i.wen   <= write;
    sys_req_i.ren   <= !write;
    @(posedge clk_250);
    sys_req_i.wen <= 1'b0;  // one cycle strobe
    sys_req_i.ren <= 1'b0;
    waited = 0;
    do
    begin
      @(negedge clk_250);
      waited++;
    end
    while (!sys_rsp_o.ack && waited < 8);
    if (!sys_rsp_o.ack)
      abort_run($sformatf("no bus acknowledge within 8 cycles for address %h", addr));
    rsp = sys_rsp_o;
  endtask

  task automatic reg_write(logic [SYS_SLOT_W-1:0] slot, logic [SYS_OFFS_W-1:0] offs,
                           logic [SYS_DATA_W-1:0] data);
    sys_rsp_t rsp;
    sys_rsp_t exp;
    bus_access(1'b1, {slot, offs}, data, rsp);
    exp.rdata = '0;
    exp.err   = (slot != SLOT_HK);  // only housekeeping is mapped
    exp.ack   = 1'b1;
    check_rsp("sys_rsp_o", rsp, exp, 1'b0);
    if (slot == SLOT_HK)
      model_write(offs, data);
  endtask

  task automatic reg_read(logic [SYS_SLOT_W-1:0] slot, logic [SYS_OFFS_W-1:0] offs);
    sys_rsp_t rsp;
    sys_rsp_t exp;
    bus_access(1'b0, {slot, offs}, '0, rsp);
    exp.rdata = (slot == SLOT_HK) ? ref_read(offs) : '0;
    exp.err   = (slot != SLOT_HK);
    exp.ack   = 1'b1;
    check_rsp("sys_rsp_o", rsp, exp, 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // sample compare and watchdog
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_250)
  begin
    if (adc_vld_o)
    begin
      if (exp_q.size() == 0)
        abort_run("adc_vld_o went high while no sample was expected");
      if (cyc != due_q[0])
        abort_run($sformatf("Error: time %0t, adc_vld_o cycle got %0d expected %0d",
                            $time, cyc, due_q[0]));
      check_sample("adc_dat_o", adc_dat_o, exp_q.pop_front());
      void'(due_q.pop_front());
    end
    else if (due_q.size() != 0 && cyc >= due_q[0])
      abort_run("an expected sample never appeared on adc_vld_o");
  end

  // bound checker failures end the run at once
  always @(negedge clk_250)
  begin
    if (rp_core_top_inst.rp_core_chk_inst.fail_cnt != 0)
      abort_run("a bound assertion on bus or sample timing failed");
  end

  initial
  begin
    #(WDOG_CYC * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, stimulus did not finish", WDOG_CYC);
    $display("Test failed");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    exp_pins_t pins_v;
    void'($urandom(32));
    rst_n_i     = 1'b0;
    adc_lanes_i = '0;
    adc_frame_i = 1'b0;
    sys_req_i   = '0;
    exp_in_i    = '0;
    mdl_dir     = '0;
    mdl_out     = '0;
    mdl_in      = '0;
    mdl_led     = '0;
    repeat (RESET_CYC) @(posedge clk_250);
    rst_n_i <= 1'b1;

    // outputs quiet after reset
    @(negedge clk_250);
    check_led("led_o", led_o, '0);
    check_pins("exp_out_o", exp_out_o, '0);
    check_pins("exp_oe_o", exp_oe_o, '0);
    check_flag("adc_vld_o", adc_vld_o, 1'b0);
    check_flag("sys_rsp_o.ack", sys_rsp_o.ack, 1'b0);

    repeat (N_SAMPLES) send_sample(rnd_lanes(), rnd_lanes());

    // lone odd beat, then a first beat that gets replaced
    @(posedge clk_250);
    adc_lanes_i <= rnd_lanes();
    adc_frame_i <= 1'b0;
    @(posedge clk_250);
    adc_lanes_i <= rnd_lanes();
    adc_frame_i <= 1'b1;
    send_sample(rnd_lanes(), rnd_lanes());
    while (exp_q.size() != 0)
      @(negedge clk_250);
    repeat (4) @(negedge clk_250);  // room for a stray vld

    for (int r = 0; r < 2; r++)
    begin
      foreach (rw_regs[i])
      begin
        reg_write(SLOT_HK, rw_regs[i], $urandom);
        reg_read(SLOT_HK, rw_regs[i]);
      end
    end
    check_led("led_o", led_o, mdl_led);
    check_pins("exp_oe_o", exp_oe_o, mdl_dir);
    check_pins("exp_out_o", exp_out_o, mdl_out);
    reg_write(SLOT_HK, REG_ID, $urandom);  // id is read only
    reg_read(SLOT_HK, REG_ID);
    reg_read(SLOT_HK, 20'h00040);          // hole

    // pins through the synchronizer
    pins_v = rnd_pins();
    @(posedge clk_250);
    exp_in_i <= pins_v;
    mdl_in = pins_v;
    repeat (3) @(posedge clk_250);
    reg_read(SLOT_HK, REG_EXP_P_IN);
    reg_read(SLOT_HK, REG_EXP_N_IN);

    // unmapped slots
    reg_write(3'd5, REG_LED, ~SYS_DATA_W'(mdl_led));
    reg_write(3'd7, REG_EXP_P_DIR, $urandom);
    reg_read(3'd0, REG_ID);
    reg_read(SLOT_HK, REG_LED);
    reg_read(SLOT_HK, REG_EXP_P_DIR);
    check_led("led_o", led_o, mdl_led);

    if (rp_core_top_inst.rp_core_chk_inst.fail_cnt == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("bound assertions failed %0d times",
               rp_core_top_inst.rp_core_chk_inst.fail_cnt);
      $display("Test failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- build.f
rtl/adc_pkg.sv
rtl/sys_bus_pkg.sv
rtl/adc_frontend.sv
rtl/sys_bus_decode.sv
rtl/hk_regs.sv
rtl/rp_core_top.sv
testbench/rp_core_chk.sv
testbench/tb_top.sv
